// ==== bx_frame_sampler.sv ====
`timescale 1ns/100ps

module bx_frame_sampler (
   input  logic                                clock_40,
   input  logic                                arst_n_i,
   input  logic                                link_up_i,
   input  logic [gem_link_pkg::GEM_DATA_W-1:0] gem_data_i,     // 112 bits of clusters
   input  logic                                overflow_i,     // More than 8 clusters
   input  logic [11:0]                         bxn_counter_i,  // Only LSBs used here
   input  logic                                bc0_i,
   input  logic                                resync_i,
   frame_if.source                             frame
);

   logic [gem_link_pkg::FRAME_PHASE_W-1:0] phase_q;
   logic                                   capture;
   logic [gem_link_pkg::GEM_DATA_W-1:0]    gem_data_q;
   logic                                   bc0_q;
   logic                                   resync_q;
   logic                                   overflow_q;
   logic [gem_link_pkg::BX_LSB_W-1:0]      bx_lsbs_q;

   // --------------------
   // Frame phase
   // --------------------
   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase_q <= '0;
      end else if (!link_up_i) begin
         phase_q <= '0;                                    // Park until links are up
      end else if (phase_q == 2'(gem_link_pkg::FRAME_WORDS - 1)) begin
         phase_q <= '0;
      end else begin
         phase_q <= phase_q + 1'b1;
      end
   end

   assign capture = link_up_i && (phase_q == '0);          // Once per 4-word frame

   // Capture registers, no reset
   always_ff @(posedge clock_40) begin
      if (capture) begin
         gem_data_q <= gem_data_i;
         bc0_q      <= bc0_i;
         resync_q   <= resync_i;
         overflow_q <= overflow_i;
         bx_lsbs_q  <= bxn_counter_i[gem_link_pkg::BX_LSB_W-1:0];
      end
   end

   // Frame out to the link framers
   assign frame.gem_data = gem_data_q;
   assign frame.bc0      = bc0_q;
   assign frame.resync   = resync_q;
   assign frame.overflow = overflow_q;
   assign frame.bx_lsbs  = bx_lsbs_q;
   assign frame.phase    = phase_q;
   assign frame.link_up  = link_up_i;

endmodule

// ==== frame_if.sv ====
`timescale 1ns/100ps

// One captured bunch-crossing frame, shared by all link framers
interface frame_if;

   logic [gem_link_pkg::GEM_DATA_W-1:0]    gem_data;   // Captured clusters, both halves
   logic                                   bc0;
   logic                                   resync;
   logic                                   overflow;
   logic [gem_link_pkg::BX_LSB_W-1:0]      bx_lsbs;    // Separator rotation select
   logic [gem_link_pkg::FRAME_PHASE_W-1:0] phase;      // Word slot, 0 means capture edge
   logic                                   link_up;    // Links ready, framers may send

   // Sampler side
   modport source (
      output gem_data, bc0, resync, overflow, bx_lsbs, phase, link_up
   );

   // Framer side, read only
   modport sink (
      input gem_data, bc0, resync, overflow, bx_lsbs, phase, link_up
   );

endinterface

// ==== gem_data_out.f ====
gem_link_pkg.sv
frame_if.sv
startup_sequencer.sv
link_ready_monitor.sv
bx_frame_sampler.sv
link_framer.sv
gem_data_out.sv
tb_clock_gen.sv
tb_gem_data_out.sv

// ==== gem_data_out.sv ====
`timescale 1ns/100ps

module gem_data_out (
   input  logic                                                  clock_40,
   input  logic                                                  arst_n_i,

   // Trigger data from the cluster finder
   input  logic [gem_link_pkg::GEM_DATA_W-1:0]                   gem_data_i,
   input  logic                                                  overflow_i,
   input  logic [11:0]                                           bxn_counter_i,
   input  logic                                                  bc0_i,
   input  logic                                                  resync_i,

   // Transceiver status and manual controls
   input  logic [gem_link_pkg::N_LINKS-1:0]                      tx_done_i,
   input  logic                                                  force_not_ready_i,
   input  logic [gem_link_pkg::N_LINKS-1:0]                      mgt_reset_i,
   input  logic                                                  txreset_i,
   input  logic                                                  gtxtest_start_i,

   // To the transceivers
   output logic [gem_link_pkg::N_LINKS*gem_link_pkg::WORD_W-1:0] tx_data_o,
   output logic [gem_link_pkg::N_LINKS*gem_link_pkg::ISK_W-1:0]  tx_isk_o,
   output logic [gem_link_pkg::N_LINKS-1:0]                      mgt_reset_o,
   output logic                                                  txreset_o,
   output logic                                                  gtxtest_reset_o,
   output logic                                                  ready_o
);

   logic link_up;                                           // Registered AND of tx_done

   frame_if u_frame ();

   // --------------------
   // Control side
   // --------------------
   startup_sequencer u_startup_sequencer (
      .clock_40        (clock_40),
      .arst_n_i        (arst_n_i),
      .link_up_i       (link_up),
      .mgt_reset_i     (mgt_reset_i),
      .txreset_i       (txreset_i),
      .gtxtest_start_i (gtxtest_start_i),
      .mgt_reset_o     (mgt_reset_o),
      .txreset_o       (txreset_o),
      .gtxtest_reset_o (gtxtest_reset_o)
   );

   link_ready_monitor u_link_ready_monitor (
      .clock_40          (clock_40),
      .arst_n_i          (arst_n_i),
      .tx_done_i         (tx_done_i),
      .force_not_ready_i (force_not_ready_i),
      .link_up_o         (link_up),
      .ready_o           (ready_o)
   );

   // --------------------
   // Data path
   // --------------------
   bx_frame_sampler u_bx_frame_sampler (
      .clock_40      (clock_40),
      .arst_n_i      (arst_n_i),
      .link_up_i     (link_up),
      .gem_data_i    (gem_data_i),
      .overflow_i    (overflow_i),
      .bxn_counter_i (bxn_counter_i),
      .bc0_i         (bc0_i),
      .resync_i      (resync_i),
      .frame         (u_frame)
   );

   // One framer per link, all fed from the same frame
   for (genvar i = 0; i < gem_link_pkg::N_LINKS; i++) begin : g_link
      link_framer #(
         .link_index (i)
      ) u_link_framer (
         .clock_40  (clock_40),
         .arst_n_i  (arst_n_i),
         .frame     (u_frame),
         .tx_data_o (tx_data_o[i*gem_link_pkg::WORD_W +: gem_link_pkg::WORD_W]),
         .tx_isk_o  (tx_isk_o[i*gem_link_pkg::ISK_W +: gem_link_pkg::ISK_W])
      );
   end

endmodule

// ==== gem_link_pkg.sv ====
package gem_link_pkg;

   // --------------------
   // Link geometry
   // --------------------
   localparam int N_LINKS       = 4;                       // Trigger links per optohybrid
   localparam int FRAME_WORDS   = 4;                       // 16-bit words per 40 MHz frame
   localparam int LINK_DATA_W   = 56;                      // Cluster bits carried by one link
   localparam int GEM_DATA_W    = 2 * LINK_DATA_W;         // Even links low half, odd links high half
   localparam int WORD_W        = 16;                      // Transceiver word width
   localparam int ISK_W         = 2;                       // One K flag per byte
   localparam int FRAME_PHASE_W = 2;                       // Word index inside a frame
   localparam int BX_LSB_W      = 2;                       // Bunch-crossing bits used for rotation

   // --------------------
   // Startup counts, clock_40 cycles
   // --------------------
   localparam int STARTUP_CNT_W = 7;
   localparam logic [STARTUP_CNT_W-1:0] STARTUP_CNT_MAX = 7'd127;

   // Staggered MGT reset release, link 0 first
   localparam logic [N_LINKS-1:0][STARTUP_CNT_W-1:0] MGT_RESET_CNT =
      {7'd60, 7'd56, 7'd48, 7'd40};

   localparam logic [STARTUP_CNT_W-1:0] GTXTEST_CNT = 7'd64;   // Test divider reset kicks off
   localparam logic [STARTUP_CNT_W-1:0] TXRESET_CNT = 7'd72;   // One-cycle PCS reset
   localparam logic [STARTUP_CNT_W-1:0] DONE_CNT    = 7'd100;  // Past this, retry if no link

   // Test-clock-divider reset windows
   localparam int GTXTEST_CNT_W = 6;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_CNT_MAX = 6'd63;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN0_LO = 6'd1;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN0_HI = 6'd15;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN1_LO = 6'd32;
   localparam logic [GTXTEST_CNT_W-1:0] GTXTEST_WIN1_HI = 6'd47;

   // Ready timer
   localparam int READY_CNT_W = 6;
   localparam logic [READY_CNT_W-1:0] READY_CNT_MAX = 6'd63;

   // --------------------
   // 8b10b K-codes
   // --------------------
   localparam logic [7:0] K_BC0      = 8'h1C;              // Orbit marker, top priority
   localparam logic [7:0] K_RESYNC   = 8'h3C;
   localparam logic [7:0] K_OVERFLOW = 8'hFC;              // More than 8 clusters on the OH

   // Normal separators, indexed by BX LSBs
   localparam logic [3:0][7:0] K_ROTATION = {8'hFD, 8'hFB, 8'hF7, 8'hBC};

   localparam logic [WORD_W-1:0] IDLE_WORD = 16'hFFFC;     // Comma filler while link is down
   localparam logic [ISK_W-1:0]  IDLE_ISK  = 2'b01;
   localparam logic [ISK_W-1:0]  ISK_HDR   = 2'b01;        // K char in the low byte only
   localparam logic [ISK_W-1:0]  ISK_DATA  = 2'b00;

   // One transmit word, read either as header or as plain payload
   typedef union packed {
      struct packed {
         logic [7:0] data;                                 // First cluster byte
         logic [7:0] sep;                                  // Frame separator K-code
      } hdr;
      logic [WORD_W-1:0] payload;
   } link_word_t;

endpackage

// ==== link_framer.sv ====
`timescale 1ns/100ps

module link_framer #(
   parameter int link_index = 0                            // Even takes low half, odd high
) (
   input  logic                             clock_40,
   input  logic                             arst_n_i,
   frame_if.sink                            frame,
   output logic [gem_link_pkg::WORD_W-1:0]  tx_data_o,
   output logic [gem_link_pkg::ISK_W-1:0]   tx_isk_o
);

   logic [gem_link_pkg::LINK_DATA_W-1:0] link_data;
   logic [7:0]                           frame_sep;
   logic                                 armed_q;           // A header went out this link-up
   gem_link_pkg::link_word_t             word_d;
   gem_link_pkg::link_word_t             word_q;
   logic [gem_link_pkg::ISK_W-1:0]       isk_d;
   logic [gem_link_pkg::ISK_W-1:0]       isk_q;

   assign link_data =
      frame.gem_data[(link_index % 2) * gem_link_pkg::LINK_DATA_W +: gem_link_pkg::LINK_DATA_W];

   // --------------------
   // Separator select
   // --------------------
   always_comb begin
      if (frame.bc0) begin
         frame_sep = gem_link_pkg::K_BC0;
      end else if (frame.resync) begin
         frame_sep = gem_link_pkg::K_RESYNC;
      end else if (frame.overflow) begin
         frame_sep = gem_link_pkg::K_OVERFLOW;
      end else begin
         frame_sep = gem_link_pkg::K_ROTATION[frame.bx_lsbs]; // TTC driven rotation
      end
   end

   // Word for the coming slot, header right after capture
   always_comb begin
      word_d.payload = '0;
      isk_d          = gem_link_pkg::ISK_DATA;
      case (frame.phase)
         2'd1: begin
            word_d.hdr.data = link_data[7:0];
            word_d.hdr.sep  = frame_sep;                    // K char in low byte
            isk_d           = gem_link_pkg::ISK_HDR;
         end
         2'd2:    word_d.payload = link_data[23:8];         // Bytes 1-2
         2'd3:    word_d.payload = link_data[39:24];        // Bytes 3-4
         default: word_d.payload = link_data[55:40];        // Bytes 5-6, overlaps next capture
      endcase
   end

   // --------------------
   // Output register
   // --------------------
   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         word_q.payload <= gem_link_pkg::IDLE_WORD;
         isk_q          <= gem_link_pkg::IDLE_ISK;
         armed_q        <= 1'b0;
      end else if (!frame.link_up) begin
         word_q.payload <= gem_link_pkg::IDLE_WORD;         // Idle commas while down
         isk_q          <= gem_link_pkg::IDLE_ISK;
         armed_q        <= 1'b0;
      end else if (frame.phase == '0 && !armed_q) begin
         word_q.payload <= gem_link_pkg::IDLE_WORD;         // Nothing captured yet
         isk_q          <= gem_link_pkg::IDLE_ISK;
      end else begin
         word_q  <= word_d;
         isk_q   <= isk_d;
         armed_q <= armed_q || (frame.phase == 2'd1);
      end
   end

   assign tx_data_o = word_q.payload;
   assign tx_isk_o  = isk_q;

   // Only the low byte ever carries a K char
   a_isk_legal : assert property (
      @(posedge clock_40) disable iff (!arst_n_i)
      (tx_isk_o == gem_link_pkg::ISK_DATA) || (tx_isk_o == gem_link_pkg::ISK_HDR)
   );

endmodule

// ==== link_ready_monitor.sv ====
`timescale 1ns/100ps

module link_ready_monitor (
   input  logic                             clock_40,
   input  logic                             arst_n_i,
   input  logic [gem_link_pkg::N_LINKS-1:0] tx_done_i,        // Per-link TX done from MGTs
   input  logic                             force_not_ready_i,
   output logic                             link_up_o,
   output logic                             ready_o
);

   logic                                 all_done;
   logic [gem_link_pkg::READY_CNT_W-1:0] ready_cnt;

   assign all_done = &tx_done_i;                              // Every link must be up

   // Single register stage on the link-up status
   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         link_up_o <= 1'b0;
      end else begin
         link_up_o <= all_done;
      end
   end

   // --------------------
   // Ready timer
   // --------------------
   // Cleared on the same edge that drops link_up
   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ready_cnt <= '0;
      end else if (!link_up_o || !all_done || force_not_ready_i) begin
         ready_cnt <= '0;
      end else if (ready_cnt < gem_link_pkg::READY_CNT_MAX) begin
         ready_cnt <= ready_cnt + 1'b1;                       // Hold at ceiling
      end
   end

   assign ready_o = (ready_cnt == gem_link_pkg::READY_CNT_MAX);

   // Timer and link-up register must drop together
   a_ready_needs_link : assert property (
      @(posedge clock_40) disable iff (!arst_n_i)
      ready_o |-> link_up_o
   );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the gem_data_out testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_gem_data_out \
   -f gem_data_out.f \
   -o tb_gem_data_out

./obj_dir/tb_gem_data_out 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi
echo "Simulation passed"

// ==== startup_sequencer.sv ====
`timescale 1ns/100ps

module startup_sequencer (
   input  logic                             clock_40,
   input  logic                             arst_n_i,
   input  logic                             link_up_i,       // From ready monitor
   input  logic [gem_link_pkg::N_LINKS-1:0] mgt_reset_i,     // Manual per-link reset
   input  logic                             txreset_i,
   input  logic                             gtxtest_start_i,
   output logic [gem_link_pkg::N_LINKS-1:0] mgt_reset_o,
   output logic                             txreset_o,
   output logic                             gtxtest_reset_o
);

   logic [gem_link_pkg::STARTUP_CNT_W-1:0] startup_cnt;
   logic [gem_link_pkg::GTXTEST_CNT_W-1:0] gtxtest_cnt;     // 0 means idle
   logic                                   startup_done;
   logic                                   retry;
   logic                                   gtxtest_start;

   // --------------------
   // Startup counter
   // --------------------
   assign startup_done = (startup_cnt > gem_link_pkg::DONE_CNT);
   assign retry        = startup_done && !link_up_i;        // Links never came up, start over

   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         startup_cnt <= '0;
      end else if (retry) begin
         startup_cnt <= '0;
      end else if (startup_cnt < gem_link_pkg::STARTUP_CNT_MAX) begin
         startup_cnt <= startup_cnt + 1'b1;                 // Saturates at ceiling
      end
   end

   // Each link held in reset until its own release point
   always_comb begin
      for (int i = 0; i < gem_link_pkg::N_LINKS; i++) begin
         mgt_reset_o[i] = mgt_reset_i[i] ||
                          (startup_cnt < gem_link_pkg::MGT_RESET_CNT[i]);
      end
   end

   assign txreset_o     = txreset_i || (startup_cnt == gem_link_pkg::TXRESET_CNT);
   assign gtxtest_start = gtxtest_start_i || (startup_cnt == gem_link_pkg::GTXTEST_CNT);

   // --------------------
   // Test divider window
   // --------------------
   always_ff @(posedge clock_40 or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gtxtest_cnt <= '0;
      end else if (gtxtest_start) begin
         gtxtest_cnt <= 6'd1;                               // Restart, first window opens
      end else if (gtxtest_cnt != '0 && gtxtest_cnt < gem_link_pkg::GTXTEST_CNT_MAX) begin
         gtxtest_cnt <= gtxtest_cnt + 1'b1;
      end
   end

   // Two reset pulses to the TX output clock dividers
   assign gtxtest_reset_o =
      (gtxtest_cnt >= gem_link_pkg::GTXTEST_WIN0_LO &&
       gtxtest_cnt <= gem_link_pkg::GTXTEST_WIN0_HI) ||
      (gtxtest_cnt >= gem_link_pkg::GTXTEST_WIN1_LO &&
       gtxtest_cnt <= gem_link_pkg::GTXTEST_WIN1_HI);

   // Automatic TX reset is a single-cycle pulse, also across a retry
   a_txreset_pulse : assert property (
      @(posedge clock_40) disable iff (!arst_n_i)
      (txreset_o && !txreset_i) |=> (!txreset_o || txreset_i)
   );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

// Free-running test clock and power-on reset
module tb_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 8
) (
   output logic clock_40,
   output logic arst_n_o
);

   initial begin
      clock_40 = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         clock_40 = ~clock_40;                              // Rising edges at 5, 15, 25 ...
      end
   end

   // Held for a fixed count of edges, released just off the edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock_40);
      #1;
      arst_n_o = 1'b1;
   end

endmodule

// ==== tb_gem_data_out.sv ====
`timescale 1ns/100ps

module tb_gem_data_out;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 8;
   localparam int DRIVE_DELAY  = 1;                         // Inputs move just after the edge
   localparam int FRAME_RUN    = 48;                        // Framed cycles per traffic pass
   localparam int HIST         = 5;                         // Depth of the input history
   // Startup plus retry, three ready waits, two traffic passes, some slack
   localparam int RUN_CYCLES   = RESET_CYCLES + 2 * (int'(gem_link_pkg::DONE_CNT) + 2) +
                                 3 * (int'(gem_link_pkg::READY_CNT_MAX) + 2) + 2 * FRAME_RUN + 20;
   localparam int WATCHDOG_NS  = 2 * RUN_CYCLES * CLK_PERIOD;

   logic                                                  clock_40;
   logic                                                  arst_n;
   logic [gem_link_pkg::GEM_DATA_W-1:0]                   gem_data    = '0;
   logic                                                  overflow    = 1'b0;
   logic [11:0]                                           bxn_counter = '0;
   logic                                                  bc0         = 1'b0;
   logic                                                  resync      = 1'b0;
   logic [gem_link_pkg::N_LINKS-1:0]                      tx_done;
   logic                                                  force_not_ready;
   logic [gem_link_pkg::N_LINKS-1:0]                      mgt_reset;
   logic                                                  txreset;
   logic                                                  gtxtest_start;
   logic [gem_link_pkg::N_LINKS*gem_link_pkg::WORD_W-1:0] tx_data;
   logic [gem_link_pkg::N_LINKS*gem_link_pkg::ISK_W-1:0]  tx_isk;
   logic [gem_link_pkg::N_LINKS-1:0]                      mgt_reset_out;
   logic                                                  txreset_out;
   logic                                                  gtxtest_reset_out;
   logic                                                  ready;
   logic [15:0]                                           lfsr_state = 16'd81;

   tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
      .clock_40 (clock_40),
      .arst_n_o (arst_n)
   );

   gem_data_out uut (
      .clock_40          (clock_40),
      .arst_n_i          (arst_n),
      .gem_data_i        (gem_data),
      .overflow_i        (overflow),
      .bxn_counter_i     (bxn_counter),
      .bc0_i             (bc0),
      .resync_i          (resync),
      .tx_done_i         (tx_done),
      .force_not_ready_i (force_not_ready),
      .mgt_reset_i       (mgt_reset),
      .txreset_i         (txreset),
      .gtxtest_start_i   (gtxtest_start),
      .tx_data_o         (tx_data),
      .tx_isk_o          (tx_isk),
      .mgt_reset_o       (mgt_reset_out),
      .txreset_o         (txreset_out),
      .gtxtest_reset_o   (gtxtest_reset_out),
      .ready_o           (ready)
   );

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [127:0] bits);
      bits = '0;
      for (int b = 0; b < n; b++) begin
         bits       = (bits << 1) | {127'd0, lfsr_state[0]};  // One step per bit taken
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   task automatic next_cycle();
      @(posedge clock_40);
      #(DRIVE_DELAY);
   endtask

   // Separator priority, ctl is {bc0, resync, overflow, bx LSBs}
   function automatic logic [7:0] separator_for(input logic [4:0] ctl);
      if (ctl[4]) begin
         return gem_link_pkg::K_BC0;
      end else if (ctl[3]) begin
         return gem_link_pkg::K_RESYNC;
      end else if (ctl[2]) begin
         return gem_link_pkg::K_OVERFLOW;
      end
      return gem_link_pkg::K_ROTATION[ctl[1:0]];
   endfunction

   // --------------------
   // Random traffic
   // --------------------
   always @(posedge clock_40) begin : drive_traffic
      logic [127:0] bits;
      #(DRIVE_DELAY);
      take_bits(gem_link_pkg::GEM_DATA_W, bits);
      gem_data = bits[gem_link_pkg::GEM_DATA_W-1:0];
      take_bits(3, bits);
      bc0 = &bits[2:0];                                     // About one cycle in eight
      take_bits(3, bits);
      resync = &bits[2:0];
      take_bits(2, bits);
      overflow = &bits[1:0];
      take_bits(1, bits);
      bxn_counter = bxn_counter + 12'd1 + {11'd0, bits[0]}; // Jitter so captures see all LSBs
   end

   // --------------------
   // Reference models
   // --------------------
   logic [gem_link_pkg::STARTUP_CNT_W-1:0] exp_startup_cnt;
   logic [gem_link_pkg::GTXTEST_CNT_W-1:0] exp_gtxtest_cnt; // 0 until the first start
   logic [gem_link_pkg::READY_CNT_W-1:0]   exp_ready_cnt;
   logic                                   exp_link_up;
   logic [1:0]                             exp_phase;       // Frame word slot
   logic [gem_link_pkg::N_LINKS-1:0]       exp_mgt_reset;
   logic [HIST-1:0][gem_link_pkg::GEM_DATA_W-1:0] data_h;  // Index 0 is the newest
   logic [HIST-1:0][4:0]                   ctl_h;
   logic [HIST-1:0]                        cap_h;           // Capture edge markers
   logic [HIST-1:0]                        up_h;            // Link up seen by the framers

   always @(posedge clock_40 or negedge arst_n) begin
      if (!arst_n) begin
         exp_startup_cnt <= '0;
         exp_gtxtest_cnt <= '0;
         exp_ready_cnt   <= '0;
         exp_link_up     <= 1'b0;
         exp_phase       <= 2'd0;
         cap_h           <= '0;
         up_h            <= '0;
      end else begin
         exp_link_up <= &tx_done;                           // One cycle of latency
         if (exp_startup_cnt > gem_link_pkg::DONE_CNT && !exp_link_up) begin
            exp_startup_cnt <= '0;                          // Retry
         end else if (exp_startup_cnt != gem_link_pkg::STARTUP_CNT_MAX) begin
            exp_startup_cnt <= exp_startup_cnt + 1'b1;
         end
         // Test window restarts at its count or on request, then runs to the ceiling
         if (gtxtest_start || exp_startup_cnt == gem_link_pkg::GTXTEST_CNT) begin
            exp_gtxtest_cnt <= 6'd1;
         end else if (exp_gtxtest_cnt != 6'd0 &&
                      exp_gtxtest_cnt != gem_link_pkg::GTXTEST_CNT_MAX) begin
            exp_gtxtest_cnt <= exp_gtxtest_cnt + 6'd1;
         end
         // Ready drops on the same edge as link up
         if (!exp_link_up || !(&tx_done) || force_not_ready) begin
            exp_ready_cnt <= '0;
         end else if (exp_ready_cnt != gem_link_pkg::READY_CNT_MAX) begin
            exp_ready_cnt <= exp_ready_cnt + 1'b1;
         end
         exp_phase <= exp_link_up ? exp_phase + 2'd1 : 2'd0;
         cap_h     <= {cap_h[HIST-2:0], exp_link_up && exp_phase == 2'd0};
         up_h      <= {up_h[HIST-2:0], exp_link_up};
      end
   end

   always @(posedge clock_40) begin
      data_h <= {data_h[HIST-2:0], gem_data};
      ctl_h  <= {ctl_h[HIST-2:0], {bc0, resync, overflow, bxn_counter[1:0]}};
   end

   // --------------------
   // Control checks
   // --------------------
   a_mgt_reset : assert property (@(posedge clock_40) disable iff (!arst_n)
      mgt_reset_out == exp_mgt_reset)
      else stop_on_error($sformatf("ERR %0t: mgt_reset_o %b, expected %b", $time,
                                   mgt_reset_out, exp_mgt_reset));

   a_txreset : assert property (@(posedge clock_40) disable iff (!arst_n)
      txreset_out == (txreset || exp_startup_cnt == gem_link_pkg::TXRESET_CNT))
      else stop_on_error($sformatf("ERR %0t: txreset_o wrong at count %0d", $time,
                                   exp_startup_cnt));

   // Divider reset is active for window counts 1 to 15 and 32 to 47
   a_gtxtest : assert property (@(posedge clock_40) disable iff (!arst_n)
      gtxtest_reset_out == ((exp_gtxtest_cnt >= 6'd1 && exp_gtxtest_cnt <= 6'd15) ||
                            (exp_gtxtest_cnt >= 6'd32 && exp_gtxtest_cnt <= 6'd47)))
      else stop_on_error($sformatf("ERR %0t: gtxtest_reset_o wrong at window count %0d",
                                   $time, exp_gtxtest_cnt));

   a_ready : assert property (@(posedge clock_40) disable iff (!arst_n)
      ready == (exp_ready_cnt == gem_link_pkg::READY_CNT_MAX))
      else stop_on_error($sformatf("ERR %0t: ready_o is %b", $time, ready));

   a_force : assert property (@(posedge clock_40) disable iff (!arst_n)
      force_not_ready |=> !ready)
      else stop_on_error($sformatf("ERR %0t: ready_o still high after force", $time));

   // --------------------
   // Per-link checks
   // --------------------
   for (genvar i = 0; i < gem_link_pkg::N_LINKS; i++) begin : g_link_chk
      logic [15:0]                                    word;
      logic [1:0]                                     isk;
      logic [HIST-1:0][gem_link_pkg::LINK_DATA_W-1:0] half_h;  // This link's data half

      assign word = tx_data[i*gem_link_pkg::WORD_W +: gem_link_pkg::WORD_W];
      assign isk  = tx_isk[i*gem_link_pkg::ISK_W +: gem_link_pkg::ISK_W];
      assign exp_mgt_reset[i] = mgt_reset[i] ||
                                (exp_startup_cnt < gem_link_pkg::MGT_RESET_CNT[i]);

      for (genvar j = 0; j < HIST; j++) begin : g_half
         assign half_h[j] = (i % 2 == 1) ? data_h[j][111:56] : data_h[j][55:0];  // Odd high
      end

      a_idle : assert property (@(posedge clock_40) disable iff (!arst_n)
         !up_h[0] |-> (word == gem_link_pkg::IDLE_WORD && isk == gem_link_pkg::IDLE_ISK))
         else stop_on_error($sformatf("ERR %0t: link %0d not idle while down", $time, i));

      // Header one edge after capture
      a_header : assert property (@(posedge clock_40) disable iff (!arst_n)
         (cap_h[1] && up_h[0]) |-> (isk == 2'b01 && word[7:0] == separator_for(ctl_h[1]) &&
                                    word[15:8] == half_h[1][7:0]))
         else stop_on_error($sformatf("ERR %0t: link %0d header %h/%b", $time, i, word, isk));

      a_payload_1 : assert property (@(posedge clock_40) disable iff (!arst_n)
         (cap_h[2] && &up_h[1:0]) |-> (isk == 2'b00 && word == half_h[2][23:8]))
         else stop_on_error($sformatf("ERR %0t: link %0d bytes 1-2 %h", $time, i, word));

      a_payload_2 : assert property (@(posedge clock_40) disable iff (!arst_n)
         (cap_h[3] && &up_h[2:0]) |-> (isk == 2'b00 && word == half_h[3][39:24]))
         else stop_on_error($sformatf("ERR %0t: link %0d bytes 3-4 %h", $time, i, word));

      a_payload_3 : assert property (@(posedge clock_40) disable iff (!arst_n)
         (cap_h[4] && &up_h[3:0]) |-> (isk == 2'b00 && word == half_h[4][55:40]))
         else stop_on_error($sformatf("ERR %0t: link %0d bytes 5-6 %h", $time, i, word));
   end

   // --------------------
   // Test sequence
   // --------------------
   initial begin : main_flow
      tx_done         = '0;
      force_not_ready = 1'b0;
      mgt_reset       = '0;
      txreset         = 1'b0;
      gtxtest_start   = 1'b0;
      @(posedge arst_n);
      next_cycle();
      while (mgt_reset_out != '0) begin                     // Staggered release
         next_cycle();
      end
      while (!txreset_out) begin
         next_cycle();
      end
      while (!mgt_reset_out[0]) begin                       // Links never came up, retry
         next_cycle();
      end
      tx_done = '1;
      while (!ready) begin
         next_cycle();
      end
      mgt_reset = 4'b0100;                                  // Manual reset on a released link
      repeat (2) next_cycle();
      mgt_reset = '0;
      repeat (FRAME_RUN) next_cycle();
      txreset       = 1'b1;                                 // Manual TX reset and divider restart
      gtxtest_start = 1'b1;
      next_cycle();
      txreset       = 1'b0;
      gtxtest_start = 1'b0;
      force_not_ready = 1'b1;
      repeat (3) next_cycle();
      force_not_ready = 1'b0;
      while (!ready) begin
         next_cycle();
      end
      tx_done = 4'b1011;                                    // One link drops
      repeat (12) next_cycle();
      tx_done = '1;
      while (!ready) begin
         next_cycle();
      end
      repeat (FRAME_RUN) next_cycle();
      $display("TEST PASSED");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      stop_on_error("Timeout: the test sequence did not finish within the watchdog limit");
   end

endmodule
